// ==== src/execPkg.sv ====
// Common sizes, command kinds and bus structs for the execution unit, imported by RTL and testbench
package execPkg;

	////////////////////
	// Sizes
	////////////////////
	localparam int DATA_W		= 32;		// Integer data path
	localparam int ISSUE_W		= 4;		// Issue number, age wraps at 16
	localparam int REG_W		= 5;		// Destination register index
	localparam int MATH_LAT		= 4;		// Cycles from accept to write-back
	localparam int MV_DEPTH		= 4;		// Register-move queue entries

	typedef logic [DATA_W-1:0]	data_t;
	typedef logic [ISSUE_W-1:0]	issueNo_t;

	////////////////////
	// Command kinds
	////////////////////
	typedef enum logic [2:0] {
		opAdd,								// src1 + src2
		opSub,								// src1 - src2
		opMul,								// src1 * src2, low word
		opFma,								// src1 * src2 + src3
		opMov,								// Copy src1 to dst
		opLoad,								// dst = mem[src1 + src2]
		opStore								// mem[src1 + src2] = src3
	} opKind_t;

	////////////////////
	// Buses
	////////////////////
	typedef struct packed {
		logic				valid;
		opKind_t			kind;
		logic [REG_W-1:0]	dst;
		issueNo_t			issueNo;
		data_t				src1;
		data_t				src2;
		data_t				src3;
	} execCmd_t;

	// Tag that follows a result to write-back
	typedef struct packed {
		logic				valid;
		logic [REG_W-1:0]	dst;
		issueNo_t			issueNo;
	} wbToken_t;

	typedef struct packed {
		wbToken_t			token;
		data_t				data;
	} wbOut_t;

	typedef struct packed {
		logic				valid;			// Held until grant
		logic				write;			// High for a store
		data_t				addr;			// Word address
		data_t				stData;
	} memReq_t;

	typedef struct packed {
		logic				valid;			// One-cycle pulse
		data_t				ldData;
	} memRsp_t;

endpackage

// ==== src/ringBuff.sv ====
// Circular FIFO for any payload type, instanced in the execution unit as the register-move queue
module ringBuff #(
	parameter type	TYPE		= logic [7:0],
	parameter int	NUM_ENTRY	= 4
)(
	input	logic	clock,
	input	logic	rstN,
	input	logic	we,					// Push, ignored when full
	input	logic	re,					// Pop, ignored when empty
	input	TYPE	dataIn,
	output	TYPE	dataOut,			// Head entry
	output	logic	full,
	output	logic	empty
);

	localparam int PTR_W = (NUM_ENTRY > 1) ? $clog2(NUM_ENTRY) : 1;
	localparam int CNT_W = $clog2(NUM_ENTRY + 1);

	TYPE				mem [NUM_ENTRY];
	logic [PTR_W-1:0]	wrPtr;
	logic [PTR_W-1:0]	rdPtr;
	logic [CNT_W-1:0]	count;			// Occupancy
	logic				doWrite;
	logic				doRead;

	assign doWrite	= we & ~full;
	assign doRead	= re & ~empty;
	assign full		= (count == CNT_W'(NUM_ENTRY));
	assign empty	= (count == '0);
	assign dataOut	= mem[rdPtr];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= (wrPtr == PTR_W'(NUM_ENTRY - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doRead) begin
				rdPtr <= (rdPtr == PTR_W'(NUM_ENTRY - 1)) ? '0 : rdPtr + 1'b1;
			end
			count <= count + CNT_W'(doWrite) - CNT_W'(doRead);	// Net change per cycle
		end
	end

	always_ff @(posedge clock) begin
		if (doWrite) begin
			mem[wrPtr] <= dataIn;
		end
	end

endmodule

// ==== src/mathUnit.sv ====
// Fixed-latency integer pipeline for add, sub, mul and fma, driven by the execution unit decoder
module mathUnit
	import execPkg::*;
(
	input	logic		clock,
	input	logic		rstN,
	input	execCmd_t	cmdIn,				// valid already qualified by decode
	output	wbOut_t		result
);

	// Stage one holds both raw results
	logic				s1Valid;
	opKind_t			s1Kind;
	logic [REG_W-1:0]	s1Dst;
	issueNo_t			s1Issue;
	data_t				s1Prod;
	data_t				s1Sum;
	data_t				s1Src3;

	// Stages two up to MATH_LAT
	logic				vld			[2:MATH_LAT];
	logic [REG_W-1:0]	dstPipe		[2:MATH_LAT];
	issueNo_t			issuePipe	[2:MATH_LAT];
	data_t				dataPipe	[2:MATH_LAT];
	data_t				s2Data;

	// Final select, fma adds the addend here
	always_comb begin
		case (s1Kind)
			opMul:		s2Data = s1Prod;
			opFma:		s2Data = s1Prod + s1Src3;
			default:	s2Data = s1Sum;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			for (int i = 2; i <= MATH_LAT; i++) begin
				vld[i] <= 1'b0;
			end
		end else begin
			s1Valid	<= cmdIn.valid;
			vld[2]	<= s1Valid;
			for (int i = 3; i <= MATH_LAT; i++) begin
				vld[i] <= vld[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		s1Kind			<= cmdIn.kind;
		s1Dst			<= cmdIn.dst;
		s1Issue			<= cmdIn.issueNo;
		s1Prod			<= cmdIn.src1 * cmdIn.src2;		// Low word of product
		s1Sum			<= (cmdIn.kind == opSub) ? cmdIn.src1 - cmdIn.src2 : cmdIn.src1 + cmdIn.src2;
		s1Src3			<= cmdIn.src3;
		dstPipe[2]		<= s1Dst;
		issuePipe[2]	<= s1Issue;
		dataPipe[2]		<= s2Data;
		for (int i = 3; i <= MATH_LAT; i++) begin
			dstPipe[i]		<= dstPipe[i-1];
			issuePipe[i]	<= issuePipe[i-1];
			dataPipe[i]		<= dataPipe[i-1];
		end
	end

	assign result.token.valid	= vld[MATH_LAT];
	assign result.token.dst		= dstPipe[MATH_LAT];
	assign result.token.issueNo	= issuePipe[MATH_LAT];
	assign result.data			= dataPipe[MATH_LAT];

endmodule

// ==== src/ldStUnit.sv ====
// One load/store lane with its own memory port, instanced for the even and odd word lanes
module ldStUnit
	import execPkg::*;
(
	input	logic		clock,
	input	logic		rstN,
	input	logic		start,				// Accepted load or store for this lane
	input	execCmd_t	cmdIn,
	output	logic		busy,
	output	memReq_t	memReq,
	input	logic		grant,				// One-cycle pulse
	input	memRsp_t	memRsp,
	output	wbToken_t	result,				// Load result waiting for write-back
	output	data_t		resultData,
	input	logic		wbTaken,			// Write-back picked this lane
	output	logic		done
);

	typedef enum logic [1:0] {
		stIdle,
		stRequest,
		stWaitData,
		stHoldResult
	} lsState_t;

	lsState_t			state;
	logic				reqWrite;
	data_t				reqAddr;
	data_t				reqData;
	logic [REG_W-1:0]	reqDst;
	issueNo_t			reqIssue;
	data_t				ldData;
	logic				launch;

	assign launch = start & (state == stIdle);

	////////////////////
	// Control FSM
	////////////////////
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state	<= stIdle;
			done	<= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				stIdle: begin
					if (start) begin
						state <= stRequest;
					end
				end
				stRequest: begin
					if (grant && reqWrite) begin
						state	<= stIdle;				// Store finishes on grant
						done	<= 1'b1;
					end else if (grant) begin
						state	<= stWaitData;
					end
				end
				stWaitData: begin
					if (memRsp.valid) begin
						state	<= stHoldResult;
						done	<= 1'b1;
					end
				end
				stHoldResult: begin
					if (wbTaken) begin
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	////////////////////
	// Payload
	////////////////////
	always_ff @(posedge clock) begin
		if (launch) begin
			reqWrite	<= (cmdIn.kind == opStore);
			reqAddr		<= cmdIn.src1 + cmdIn.src2;	// Base plus offset
			reqData		<= cmdIn.src3;
			reqDst		<= cmdIn.dst;
			reqIssue	<= cmdIn.issueNo;
		end
		if ((state == stWaitData) && memRsp.valid) begin
			ldData <= memRsp.ldData;
		end
	end

	assign busy				= (state != stIdle);
	assign memReq.valid		= (state == stRequest);
	assign memReq.write		= reqWrite;
	assign memReq.addr		= reqAddr;
	assign memReq.stData	= reqData;

	assign result.valid		= (state == stHoldResult);
	assign result.dst		= reqDst;
	assign result.issueNo	= reqIssue;
	assign resultData		= ldData;

endmodule

// ==== src/execUnit.sv ====
// Top of the vector-lane execution unit: decode, stall, move queue and age-ordered write-back
module execUnit
	import execPkg::*;
(
	input	logic		clock,
	input	logic		rstN,
	input	execCmd_t	cmd,
	output	logic		stall,				// Combinational, driver holds cmd
	output	memReq_t	memReq0,			// Even lane
	output	memReq_t	memReq1,			// Odd lane
	input	logic [1:0]	grant,
	input	memRsp_t	memRsp0,
	input	memRsp_t	memRsp1,
	output	wbOut_t		wb,
	output	logic		mathDone,
	output	logic [1:0]	ldStDone
);

	////////////////////
	// Decode and stall
	////////////////////
	logic		isMath;
	logic		isLdSt;
	logic		isMov;
	data_t		lsAddr;
	logic		laneSel;				// Word address bit 0
	logic [1:0]	laneBusy;
	logic [1:0]	laneStart;
	logic		accept;
	logic		mvFull;
	logic		mvEmpty;
	issueNo_t	lastIssue;
	execCmd_t	mathCmd;

	assign isMath	= cmd.kind inside {opAdd, opSub, opMul, opFma};
	assign isLdSt	= (cmd.kind == opLoad) || (cmd.kind == opStore);
	assign isMov	= (cmd.kind == opMov);
	assign lsAddr	= cmd.src1 + cmd.src2;
	assign laneSel	= lsAddr[0];

	assign stall	= cmd.valid & ((isLdSt & laneBusy[laneSel]) | (isMov & mvFull));
	assign accept	= cmd.valid & ~stall;

	assign laneStart[0] = accept & isLdSt & ~laneSel;
	assign laneStart[1] = accept & isLdSt & laneSel;

	always_comb begin
		mathCmd			= cmd;
		mathCmd.valid	= accept & isMath;
	end

	// Reference point for ages
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			lastIssue <= '0;
		end else if (accept) begin
			lastIssue <= cmd.issueNo;
		end
	end

	////////////////////
	// Execution paths
	////////////////////
	wbOut_t		mathRes;
	wbToken_t	ldTok [2];
	data_t		ldData [2];
	logic [1:0]	ldTaken;
	wbToken_t	mvTokIn;
	wbToken_t	mvTok;
	data_t		mvData;
	logic		mvWe;
	logic		mvRe;

	mathUnit mathPipe (
		.clock(		clock		),
		.rstN(		rstN		),
		.cmdIn(		mathCmd		),
		.result(	mathRes		)
	);

	ldStUnit ldStEven (
		.clock(		clock			),
		.rstN(		rstN			),
		.start(		laneStart[0]	),
		.cmdIn(		cmd				),
		.busy(		laneBusy[0]		),
		.memReq(	memReq0			),
		.grant(		grant[0]		),
		.memRsp(	memRsp0			),
		.result(	ldTok[0]		),
		.resultData(ldData[0]		),
		.wbTaken(	ldTaken[0]		),
		.done(		ldStDone[0]		)
	);

	ldStUnit ldStOdd (
		.clock(		clock			),
		.rstN(		rstN			),
		.start(		laneStart[1]	),
		.cmdIn(		cmd				),
		.busy(		laneBusy[1]		),
		.memReq(	memReq1			),
		.grant(		grant[1]		),
		.memRsp(	memRsp1			),
		.result(	ldTok[1]		),
		.resultData(ldData[1]		),
		.wbTaken(	ldTaken[1]		),
		.done(		ldStDone[1]		)
	);

	assign mvWe				= accept & isMov;
	assign mvTokIn.valid	= 1'b1;
	assign mvTokIn.dst		= cmd.dst;
	assign mvTokIn.issueNo	= cmd.issueNo;

	ringBuff #(
		.TYPE(		wbToken_t	),
		.NUM_ENTRY(	MV_DEPTH	)
	) mvTokenBuff (
		.clock(		clock		),
		.rstN(		rstN		),
		.we(		mvWe		),
		.re(		mvRe		),
		.dataIn(	mvTokIn		),
		.dataOut(	mvTok		),
		.full(		mvFull		),
		.empty(		mvEmpty		)
	);

	ringBuff #(
		.TYPE(		data_t		),
		.NUM_ENTRY(	MV_DEPTH	)
	) mvDataBuff (
		.clock(		clock		),
		.rstN(		rstN		),
		.we(		mvWe		),
		.re(		mvRe		),
		.dataIn(	cmd.src1	),
		.dataOut(	mvData		),
		.full(					),
		.empty(					)
	);

	////////////////////
	// Write-back select
	////////////////////
	issueNo_t	ageEven;
	issueNo_t	ageOdd;
	issueNo_t	ageLd;
	issueNo_t	ageMv;
	logic		selOdd;
	logic		ldAny;
	logic		selMv;

	assign ageEven	= lastIssue - ldTok[0].issueNo;
	assign ageOdd	= lastIssue - ldTok[1].issueNo;
	assign ageMv	= lastIssue - mvTok.issueNo;

	// Oldest load first, then against the queue head
	assign selOdd	= ldTok[1].valid & (~ldTok[0].valid | (ageOdd > ageEven));
	assign ldAny	= ldTok[0].valid | ldTok[1].valid;
	assign ageLd	= selOdd ? ageOdd : ageEven;
	assign selMv	= ~mvEmpty & (~ldAny | (ageMv > ageLd));

	always_comb begin
		wb		= '0;
		ldTaken	= '0;
		mvRe	= 1'b0;
		if (mathRes.token.valid) begin
			wb = mathRes;							// Fixed latency, never waits
		end else if (selMv) begin
			wb.token	= mvTok;
			wb.data		= mvData;
			mvRe		= 1'b1;
		end else if (selOdd) begin
			wb.token	= ldTok[1];
			wb.data		= ldData[1];
			ldTaken[1]	= 1'b1;
		end else if (ldAny) begin
			wb.token	= ldTok[0];
			wb.data		= ldData[0];
			ldTaken[0]	= 1'b1;
		end
	end

	assign mathDone = mathRes.token.valid;

endmodule

// ==== verification/tbExecUnit.sv ====
// Testbench for the execution unit that reads the stimulus file, models lane memory and checks results
module tbExecUnit
	import execPkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 200;

	logic		clock;
	logic		rstN;
	execCmd_t	cmd;
	logic		stall;
	memReq_t	memReq0;
	memReq_t	memReq1;
	logic [1:0]	grant;
	memRsp_t	rsps [2];
	wbOut_t		wb;
	logic		mathDone;
	logic [1:0]	ldStDone;

	memReq_t	reqs [2];
	data_t		memory [256];
	execCmd_t	cmdQ [$];
	memReq_t	expStores [$];
	data_t		expData [32];
	int			expCount [32];
	issueNo_t	expIssue [32];
	int			dueCycle [$];
	logic [4:0]	dueDst [$];
	int			cycle;
	int			seed = 11;
	int			valueErrors;
	int			otherErrors;
	int			mvStallCycles;				// Moves held back by a full queue
	int			bothLanesCycles;			// Both request valids high together

	execUnit DUT (
		.clock(clock), .rstN(rstN), .cmd(cmd), .stall(stall),
		.memReq0(memReq0), .memReq1(memReq1), .grant(grant),
		.memRsp0(rsps[0]), .memRsp1(rsps[1]),
		.wb(wb), .mathDone(mathDone), .ldStDone(ldStDone)
	);

	assign reqs[0] = memReq0;
	assign reqs[1] = memReq1;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) cycle++;

	task automatic compareWb(input wbOut_t got, input wbOut_t exp);
		if (got !== exp) begin
			$display("Fail wb: got %h expected %h", got, exp);
			valueErrors++;
		end
	endtask

	task automatic compareReq(input string name, input memReq_t got, input memReq_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			valueErrors++;
		end
	endtask

	// Reads commands, expected write-backs and expected stores
	task automatic loadStimulus();
		int			fd;
		int			n;
		byte		tag;
		logic [31:0] f0, f1, f2, f3, f4;
		logic [8*200-1:0] junk;
		execCmd_t	c;
		memReq_t	r;
		fd = $fopen("verification/execStimulus.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open the stimulus file");
			otherErrors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, " %c", tag);
			if (n != 1) begin
				break;
			end
			if (tag == "#") begin
				n = $fgets(junk, fd);
			end else if (tag == "C") begin
				n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
				c = '0;
				c.valid	= 1'b1;
				c.kind	= opKind_t'(f0[2:0]);
				c.dst	= f1[4:0];
				c.src1	= f2;
				c.src2	= f3;
				c.src3	= f4;
				cmdQ.push_back(c);
			end else if (tag == "W") begin
				n = $fscanf(fd, "%h %h", f0, f1);
				expData[f0[4:0]]	= f1;
				expCount[f0[4:0]]	= expCount[f0[4:0]] + 1;
			end else if (tag == "S") begin
				n = $fscanf(fd, "%h %h", f0, f1);
				r		= '0;
				r.valid	= 1'b1;
				r.write	= 1'b1;
				r.addr	= f0;
				r.stData = f1;
				expStores.push_back(r);
			end
		end
		$fclose(fd);
	endtask

	// Grants requests and answers loads for one lane
	task automatic laneMemory(input int lane);
		int		d;
		int		idx;
		memReq_t	r;
		forever begin
			@(negedge clock);
			if (reqs[lane].valid) begin
				r = reqs[lane];
				if (r.addr[0] != lane[0]) begin
					$display("Error: address %h requested on lane %0d", r.addr, lane);
					otherErrors++;
				end
				d = $unsigned($random(seed)) % 4;
				repeat (d) @(posedge clock);
				@(posedge clock) #1 grant[lane] = 1'b1;
				@(posedge clock) #1 grant[lane] = 1'b0;
				if (r.write) begin
					idx = -1;
					foreach (expStores[i]) begin
						if (expStores[i].addr == r.addr && idx < 0) begin
							idx = i;
						end
					end
					if (idx < 0) begin
						$display("Error: store to an unexpected address on lane %0d", lane);
						otherErrors++;
					end else begin
						compareReq(lane ? "memReq1" : "memReq0", r, expStores[idx]);
						expStores.delete(idx);
					end
					memory[r.addr[7:0]] = r.stData;
					@(negedge clock);
					if (!ldStDone[lane]) begin
						$display("Error: no done pulse the cycle after a store grant");
						otherErrors++;
					end
				end else begin
					d = $unsigned($random(seed)) % 4;
					repeat (d) @(posedge clock);
					#1 rsps[lane] = '{valid: 1'b1, ldData: memory[r.addr[7:0]]};
					@(posedge clock) #1 rsps[lane] = '0;
				end
			end
		end
	endtask

	// Drives one command and waits until it is accepted
	task automatic issueCmd(input execCmd_t c, input issueNo_t num);
		int wait_;
		c.issueNo = num;
		cmd = c;
		if (c.kind != opStore) expIssue[c.dst] = num;
		wait_ = 0;
		forever begin
			@(negedge clock);
			if (!stall) break;
			if (c.kind == opMov) begin
				mvStallCycles++;
			end
			wait_++;
			if (wait_ >= TIMEOUT) begin
				$display("Error: command stayed stalled too long");
				otherErrors++;
				break;
			end
		end
		if (c.kind inside {opAdd, opSub, opMul, opFma}) begin
			dueCycle.push_back(cycle + MATH_LAT);
			dueDst.push_back(c.dst);
		end
		@(posedge clock) #1;
	endtask

	// Write-back monitor
	initial begin
		wbOut_t exp;
		@(posedge rstN);
		forever begin
			@(negedge clock);
			if (memReq0.valid && memReq1.valid) begin
				bothLanesCycles++;
			end
			if (dueCycle.size() > 0 && dueCycle[0] == cycle) begin
				if (!mathDone || !wb.token.valid || wb.token.dst != dueDst[0]) begin
					$display("Error: math result missing at its fixed latency");
					otherErrors++;
				end
				void'(dueCycle.pop_front());
				void'(dueDst.pop_front());
			end else if (mathDone) begin
				$display("Error: math done pulse with no math result due");
				otherErrors++;
			end
			if (wb.token.valid) begin
				if (expCount[wb.token.dst] == 0) begin
					$display("Error: write-back to register %0d not expected", wb.token.dst);
					otherErrors++;
				end else begin
					exp = '{token: '{1'b1, wb.token.dst, expIssue[wb.token.dst]},
						data: expData[wb.token.dst]};
					compareWb(wb, exp);
					expCount[wb.token.dst]--;
				end
			end
		end
	end

	initial begin
		int			pending;
		int			wait_;
		issueNo_t	num;
		cmd		= '0;
		grant	= '0;
		rsps[0]	= '0;
		rsps[1]	= '0;
		rstN	= 1'b0;
		foreach (memory[i]) memory[i] = 32'hA5000000 | i;	// Address in low byte
		foreach (expCount[i]) expCount[i] = 0;
		loadStimulus();
		fork
			laneMemory(0);
			laneMemory(1);
		join_none
		repeat (3) @(posedge clock);
		#1 rstN = 1'b1;
		@(negedge clock);
		if (wb.token.valid || memReq0.valid || memReq1.valid || stall) begin
			$display("Error: outputs not idle after reset");
			otherErrors++;
		end
		@(posedge clock) #1;
		num = '0;
		foreach (cmdQ[i]) begin
			issueCmd(cmdQ[i], num);
			num++;
		end
		cmd = '0;
		wait_ = 0;
		forever begin
			pending = expStores.size() + dueCycle.size();
			foreach (expCount[i]) pending += expCount[i];
			if (pending == 0) break;
			@(negedge clock);
			wait_++;
			if (wait_ >= TIMEOUT) begin
				$display("Error: results still missing after the last command");
				otherErrors++;
				break;
			end
		end
		if (mvStallCycles == 0) begin
			$display("Error: a move never stalled on a full queue");
			otherErrors++;
		end
		if (bothLanesCycles == 0) begin
			$display("Error: the two lanes never requested memory at the same time");
			otherErrors++;
		end
		repeat (2) @(posedge clock);
		$display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verification/execStimulus.txt ====
# C kind dst src1 src2 src3 (kind 0 add 1 sub 2 mul 3 fma 4 mov 5 load 6 store)
# W dst expectedData, S addr expectedStoreData, all hex
C 0 01 00000005 00000007 00000000
C 1 02 00000010 00000003 00000000
C 2 03 00000006 00000007 00000000
C 3 04 00000003 00000004 00000005
C 1 05 00000000 00000001 00000000
C 6 00 00000010 00000002 DEADBEEF
C 6 00 00000020 00000001 12345678
C 5 06 00000012 00000000 00000000
C 5 07 00000021 00000000 00000000
C 5 08 00000040 00000000 00000000
C 5 09 00000033 00000000 00000000
C 0 0A 00000001 00000001 00000000
C 0 0B 00000002 00000002 00000000
C 2 0C 00000003 00000003 00000000
C 3 0D 00000002 00000003 00000001
C 4 0E 11111111 00000000 00000000
C 4 0F 22222222 00000000 00000000
C 4 10 33333333 00000000 00000000
C 4 11 44444444 00000000 00000000
C 4 12 55555555 00000000 00000000
W 01 0000000C
W 02 0000000D
W 03 0000002A
W 04 00000011
W 05 FFFFFFFF
W 06 DEADBEEF
W 07 12345678
W 08 A5000040
W 09 A5000033
W 0A 00000002
W 0B 00000004
W 0C 00000009
W 0D 00000007
W 0E 11111111
W 0F 22222222
W 10 33333333
W 11 44444444
W 12 55555555
S 00000012 DEADBEEF
S 00000021 12345678

// ==== execUnit.f ====
src/execPkg.sv
src/ringBuff.sv
src/mathUnit.sv
src/ldStUnit.sv
src/execUnit.sv
verification/tbExecUnit.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds and runs the execution unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f execUnit.f \
	--top-module tbExecUnit --Mdir obj_dir -o simExec
./obj_dir/simExec > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: PASS" sim.log; then
	exit 0
else
	exit 1
fi
